/* src.f */
rtl/spl_pkg.sv
rtl/flit_if.sv
rtl/spl_symbol_decoder.sv
rtl/spl_pkt_assembler.sv
rtl/spl_pkt_fifo.sv
rtl/spl_link_receiver.sv
sim/spl_link_receiver_tb.sv

/* sim/spl_link_receiver_tb.sv */
// testbench for the link receiver
// link sender is modelled at symbol level with one symbol in flight
// the link starts at all zeros as the decoder expects after reset
// random stimulus from a 16-bit Galois LFSR with a fixed seed

`timescale 1ns/1ps

module spl_link_receiver_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int FLITS_SHORT = 10;
  localparam int FLITS_LONG = 18;
  localparam spl_pkg::symbol_t EOP_CODE = 7'b1100000;
  // two wires but not in the code table
  localparam spl_pkg::symbol_t BAD_CODE = 7'b0000101;

  logic tb_clk;
  logic tb_rst;
  spl_pkg::symbol_t sl_data;
  logic sl_ack;
  spl_pkg::pkt_t pkt_data;
  logic pkt_vld;
  logic pkt_rdy;
  spl_pkg::drop_cnt_t drop_cnt;

  spl_pkg::pkt_t exp_q [$];
  spl_pkg::pkt_t bp_pkts [8];
  spl_pkg::pkt_t p;
  spl_pkg::pkt_t held_data;
  spl_pkg::symbol_t link_sym;
  logic [15:0] lfsr_q;
  logic [31:0] rdy_bit;
  logic hold_chk;
  logic stall_win;
  logic stall_ack;
  logic ack_q;
  int rdy_mode;
  int err_cnt;
  int errs_at;
  int test_cnt;
  int rx_cnt;
  int exp_drop;
  int sym_sent;
  int ack_cnt;
  int acks_at;
  int full_syms;
  int cyc_cnt;
  int i;

  spl_link_receiver #(.FIFO_DEPTH (FIFO_DEPTH)) i_dut
  (
    .tb_clk   (tb_clk),
    .tb_rst   (tb_rst),
    .sl_data  (sl_data),
    .sl_ack   (sl_ack),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .drop_cnt (drop_cnt)
  );

  initial
  begin
    tb_clk = 1'b0;
    forever #10 tb_clk = ~tb_clk;
  end

  // ------------------------------
  // random numbers
  // ------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    take_bits = v;
  endfunction

  // ------------------------------
  // link sender
  // ------------------------------
  // nibble to transition pattern
  function automatic spl_pkg::symbol_t code_of(input logic [3:0] n);
    case (n)
      4'd0: code_of = 7'b0010001;
      4'd1: code_of = 7'b0010010;
      4'd2: code_of = 7'b0010100;
      4'd3: code_of = 7'b0011000;
      4'd4: code_of = 7'b0100001;
      4'd5: code_of = 7'b0100010;
      4'd6: code_of = 7'b0100100;
      4'd7: code_of = 7'b0101000;
      4'd8: code_of = 7'b1000001;
      4'd9: code_of = 7'b1000010;
      4'd10: code_of = 7'b1000100;
      4'd11: code_of = 7'b1001000;
      4'd12: code_of = 7'b0000011;
      4'd13: code_of = 7'b0000110;
      4'd14: code_of = 7'b0001100;
      default: code_of = 7'b0001001;
    endcase
  endfunction

  function automatic int flit_count(input spl_pkg::pkt_t pk);
    flit_count = pk[1] ? FLITS_LONG : FLITS_SHORT;
  endfunction

  // random header and key with payload only when flagged
  function automatic spl_pkg::pkt_t make_pkt(input logic pld);
    spl_pkg::pkt_t pk;
    logic [31:0] hdr;
    hdr = take_bits(8);
    pk[7:0] = hdr[7:0];
    pk[1] = pld;
    pk[39:8] = take_bits(32);
    pk[71:40] = pld ? take_bits(32) : 32'h0;
    make_pkt = pk;
  endfunction

  // called on a falling edge and returns on one
  task automatic send_symbol(input spl_pkg::symbol_t code);
    logic old_ack;
    logic [31:0] idle;
    old_ack = sl_ack;
    link_sym = link_sym ^ code;
    sl_data = link_sym;
    sym_sent++;
    while (sl_ack == old_ack)
      @(negedge tb_clk);
    idle = take_bits(2);
    repeat (idle) @(negedge tb_clk);
  endtask

  // bad_at below zero means a clean packet
  task automatic send_packet(input spl_pkg::pkt_t pk, input int nflits, input int bad_at);
    for (int k = 0; k < nflits; k++)
    begin
      if (k == bad_at)
        send_symbol(BAD_CODE);
      else
        send_symbol(code_of(pk[4*k +: 4]));
    end
    send_symbol(EOP_CODE);
  endtask

  task automatic send_good(input spl_pkg::pkt_t pk);
    exp_q.push_back(pk);
    send_packet(pk, flit_count(pk), -1);
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic check_idle(input string when);
    assert (sl_ack == 1'b0 && pkt_vld == 1'b0 && drop_cnt == '0)
    else
    begin
      $display("ERR %0t: outputs not idle %s", $time, when);
      err_cnt++;
    end
  endtask

  task automatic check_drops;
    assert (drop_cnt == exp_drop)
    else
    begin
      $display("ERR %0t: drop_cnt %0d, expected %0d", $time, drop_cnt, exp_drop);
      err_cnt++;
    end
  endtask

  task automatic wait_drain;
    while (exp_q.size() != 0)
      @(negedge tb_clk);
    repeat (3) @(negedge tb_clk);
    assert (!pkt_vld)
    else
    begin
      $display("ERR %0t: extra packet %h after drain", $time, pkt_data);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  // scoreboard on every output transfer
  always @(posedge tb_clk)
  begin
    if (!tb_rst && pkt_vld && pkt_rdy)
    begin
      assert (exp_q.size() > 0 && pkt_data == exp_q[0])
      else
      begin
        $display("ERR %0t: got packet %h, expected %h", $time, pkt_data,
                 (exp_q.size() > 0) ? exp_q[0] : '0);
        err_cnt++;
      end
      if (exp_q.size() > 0)
        void'(exp_q.pop_front());
      rx_cnt++;
    end
  end

  // stalled output holds and sender stalls while full
  always @(posedge tb_clk)
  begin
    if (tb_rst)
    begin
      hold_chk <= 1'b0;
    end
    else
    begin
      if (hold_chk)
      begin
        assert (pkt_vld && pkt_data == held_data)
        else
        begin
          $display("ERR %0t: output changed while stalled", $time);
          err_cnt++;
        end
      end
      if (stall_win)
      begin
        assert (sl_ack == stall_ack)
        else
        begin
          $display("ERR %0t: ack toggled with the receiver full", $time);
          err_cnt++;
        end
      end
      hold_chk  <= pkt_vld && !pkt_rdy;
      held_data <= pkt_data;
    end
    if (!tb_rst && sl_ack != ack_q)
      ack_cnt++;
    ack_q <= sl_ack;
  end

  // rdy_mode picks pkt_rdy low, high or random
  always @(negedge tb_clk)
  begin
    if (rdy_mode == 2)
    begin
      rdy_bit = take_bits(1);
      pkt_rdy = rdy_bit[0];
    end
    else
    begin
      pkt_rdy = (rdy_mode == 1);
    end
  end

  // budget grows with every symbol sent
  always @(posedge tb_clk)
  begin
    cyc_cnt++;
    if (cyc_cnt > 40 * sym_sent + 200)
    begin
      $display("timeout after %0d cycles with %0d symbols sent", cyc_cnt, sym_sent);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    tb_rst = 1'b1;
    sl_data = '0;
    pkt_rdy = 1'b0;
    link_sym = '0;
    lfsr_q = 16'd36569;
    rdy_mode = 0;
    stall_win = 1'b0;
    stall_ack = 1'b0;
    err_cnt = 0;
    test_cnt = 0;
    rx_cnt = 0;
    exp_drop = 0;
    sym_sent = 0;
    ack_cnt = 0;
    cyc_cnt = 0;

    errs_at = err_cnt;
    repeat (3)
    begin
      @(negedge tb_clk);
      check_idle("in reset");
    end
    tb_rst = 1'b0;
    @(negedge tb_clk);
    check_idle("after reset");
    end_test("reset", errs_at);

    errs_at = err_cnt;
    rdy_mode = 1;
    for (i = 0; i < 6; i++)
      send_good(make_pkt((i % 3) != 1));
    wait_drain;
    end_test("ordered delivery", errs_at);

    // FIFO plus assembler hold FIFO_DEPTH + 1 packets
    errs_at = err_cnt;
    rdy_mode = 0;
    for (i = 0; i < 8; i++)
      bp_pkts[i] = make_pkt(i[0]);
    full_syms = 0;
    for (i = 0; i <= FIFO_DEPTH; i++)
      full_syms += flit_count(bp_pkts[i]) + 1;
    acks_at = ack_cnt;
    fork
      begin
        for (int k = 0; k < 8; k++)
          send_good(bp_pkts[k]);
      end
      begin
        while (ack_cnt - acks_at < full_syms)
          @(negedge tb_clk);
        stall_ack = sl_ack;
        stall_win = 1'b1;
        repeat (100) @(negedge tb_clk);
        stall_win = 1'b0;
        assert (pkt_vld && ack_cnt - acks_at == full_syms)
        else
        begin
          $display("ERR %0t: %0d acks in stall, expected %0d", $time,
                   ack_cnt - acks_at, full_syms);
          err_cnt++;
        end
        rdy_mode = 2;
      end
    join
    wait_drain;
    end_test("back-pressure", errs_at);

    errs_at = err_cnt;
    rdy_mode = 1;
    p = make_pkt(1'b1);
    send_packet(p, FLITS_LONG - 1, -1);
    exp_drop++;
    check_drops();
    send_good(make_pkt(1'b0));
    p = make_pkt(1'b0);
    send_packet(p, FLITS_SHORT + 1, -1);
    exp_drop++;
    check_drops();
    send_good(make_pkt(1'b1));
    send_good(make_pkt(1'b0));
    wait_drain;
    end_test("length errors", errs_at);

    errs_at = err_cnt;
    p = make_pkt(1'b1);
    send_packet(p, FLITS_LONG, 6);
    exp_drop++;
    check_drops();
    send_good(make_pkt(1'b0));
    send_good(make_pkt(1'b1));
    wait_drain;
    check_drops();
    end_test("invalid symbol", errs_at);

    $display("tests %0d, packets %0d, drops %0d, errors %0d", test_cnt, rx_cnt,
             drop_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* rtl/spl_link_receiver.sv */
// link receiver top: symbol decoder, packet assembler, packet FIFO
// sl_data is asynchronous and is synchronised inside the decoder
// FIFO_DEPTH must be a power of two, at least 2
// back-pressure on pkt_rdy stalls the link through the ack

`timescale 1ns/1ps

module spl_link_receiver
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic               tb_clk,
  input  logic               tb_rst,

  // self-timed link
  input  spl_pkg::symbol_t   sl_data,
  output logic               sl_ack,

  // packet output
  output spl_pkg::pkt_t      pkt_data,
  output logic               pkt_vld,
  input  logic               pkt_rdy,

  // dropped packet count
  output spl_pkg::drop_cnt_t drop_cnt
);

  // ------------------------------
  // internal channels
  // ------------------------------
  flit_if i_flit ();

  spl_pkg::pkt_t asm_pkt;
  logic          asm_vld;
  logic          asm_rdy;

  // ------------------------------
  // blocks
  // ------------------------------
  spl_symbol_decoder i_decoder
  (
    .tb_clk  (tb_clk),
    .tb_rst  (tb_rst),
    .sl_data (sl_data),
    .sl_ack  (sl_ack),
    .flit    (i_flit.sender)
  );

  spl_pkt_assembler i_assembler
  (
    .tb_clk   (tb_clk),
    .tb_rst   (tb_rst),
    .flit     (i_flit.receiver),
    .asm_pkt  (asm_pkt),
    .asm_vld  (asm_vld),
    .asm_rdy  (asm_rdy),
    .drop_cnt (drop_cnt)
  );

  spl_pkt_fifo #(.FIFO_DEPTH (FIFO_DEPTH)) i_fifo
  (
    .tb_clk  (tb_clk),
    .tb_rst  (tb_rst),
    .in_pkt  (asm_pkt),
    .in_vld  (asm_vld),
    .in_rdy  (asm_rdy),
    .out_pkt (pkt_data),
    .out_vld (pkt_vld),
    .out_rdy (pkt_rdy)
  );

endmodule

/* rtl/spl_pkt_fifo.sv */
// single-clock packet FIFO, valid/ready on both ports
// FIFO_DEPTH must be a power of two, at least 2
// output is read straight from the array, no output register

`timescale 1ns/1ps

module spl_pkt_fifo
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic          tb_clk,
  input  logic          tb_rst,
  input  spl_pkg::pkt_t in_pkt,
  input  logic          in_vld,
  output logic          in_rdy,
  output spl_pkg::pkt_t out_pkt,
  output logic          out_vld,
  input  logic          out_rdy
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // ------------------------------
  // storage and pointers
  // ------------------------------
  spl_pkg::pkt_t mem [FIFO_DEPTH];

  // extra msb tells full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic do_wr;
  logic do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W])
              && (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign in_rdy  = !full;
  assign out_vld = !empty;

  assign do_wr = in_vld && in_rdy;
  assign do_rd = out_vld && out_rdy;

  // ------------------------------
  // pointer update
  // ------------------------------
  // read and write may both happen in one cycle
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // array write
  always_ff @(posedge tb_clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_pkt;
    end
  end

  // head of queue
  assign out_pkt = mem[rd_ptr[ADDR_W-1:0]];

endmodule

/* rtl/spl_pkt_assembler.sv */
// builds 72-bit packets from flits, low nibble first
// a packet is 10 flits, or 18 when the header payload bit is set
// damaged packets are dropped whole and counted, the count saturates
// short packets leave with the payload field cleared

`timescale 1ns/1ps

module spl_pkt_assembler
(
  input  logic               tb_clk,
  input  logic               tb_rst,
  flit_if.receiver           flit,
  output spl_pkg::pkt_t      asm_pkt,
  output logic               asm_vld,
  input  logic               asm_rdy,
  output spl_pkg::drop_cnt_t drop_cnt
);

  // ------------------------------
  // signals
  // ------------------------------
  spl_pkg::asm_state_e state_q;
  spl_pkg::flit_cnt_t  flit_cnt;
  spl_pkg::pkt_t       pkt_q;

  logic               flit_take;
  logic               take_data;
  logic               take_eop;
  logic               take_bad;
  logic               has_pld;
  spl_pkg::flit_cnt_t exp_cnt;
  logic               len_ok;
  logic               too_many;
  logic               drop_now;

  // ------------------------------
  // flit classification
  // ------------------------------
  // no flits accepted while a packet waits for the FIFO
  assign flit.flit_rdy = (state_q != spl_pkg::ASM_HOLD);

  assign flit_take = flit.flit_vld && flit.flit_rdy;
  assign take_data = flit_take && (flit.flit_kind == spl_pkg::FLIT_DATA);
  assign take_eop  = flit_take && (flit.flit_kind == spl_pkg::FLIT_EOP);
  assign take_bad  = flit_take && (flit.flit_kind == spl_pkg::FLIT_BAD);

  // header bit is in the first nibble, valid once a flit is in
  assign has_pld = pkt_q[spl_pkg::HDR_LSB + spl_pkg::HDR_PLD_BIT];
  assign exp_cnt = has_pld ? spl_pkg::FLITS_LONG : spl_pkg::FLITS_SHORT;
  assign len_ok  = (flit_cnt == exp_cnt);

  // a data flit past the longest packet
  assign too_many = (flit_cnt == spl_pkg::FLITS_LONG);

  // packet lost at this flit
  assign drop_now = ((state_q == spl_pkg::ASM_COLLECT) && take_eop && !len_ok)
                 || ((state_q == spl_pkg::ASM_DISCARD) && take_eop);

  // ------------------------------
  // FSM
  // ------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      state_q  <= spl_pkg::ASM_COLLECT;
      flit_cnt <= '0;
    end
    else
    begin
      case (state_q)
        spl_pkg::ASM_COLLECT:
        begin
          if (take_bad || (take_data && too_many))
          begin
            state_q <= spl_pkg::ASM_DISCARD;
          end
          else if (take_data)
          begin
            flit_cnt <= flit_cnt + 1'b1;
          end
          else if (take_eop)
          begin
            // good length goes out, bad length is dropped here
            flit_cnt <= '0;
            if (len_ok)
            begin
              state_q <= spl_pkg::ASM_HOLD;
            end
          end
        end

        spl_pkg::ASM_HOLD:
        begin
          if (asm_rdy)
          begin
            state_q <= spl_pkg::ASM_COLLECT;
          end
        end

        spl_pkg::ASM_DISCARD:
        begin
          // skip everything up to the end mark
          if (take_eop)
          begin
            state_q  <= spl_pkg::ASM_COLLECT;
            flit_cnt <= '0;
          end
        end

        default:
        begin
          state_q  <= spl_pkg::ASM_COLLECT;
          flit_cnt <= '0;
        end
      endcase
    end
  end

  // ------------------------------
  // packet register
  // ------------------------------
  always_ff @(posedge tb_clk)
  begin
    if (state_q == spl_pkg::ASM_COLLECT)
    begin
      if (take_data && !too_many)
      begin
        pkt_q[{flit_cnt, 2'b00} +: 4] <= flit.flit_data;
      end
      else if (take_eop && !has_pld)
      begin
        // no payload flits arrived, clear stale bits
        pkt_q[spl_pkg::PLD_LSB +: spl_pkg::PLD_W] <= '0;
      end
    end
  end

  assign asm_pkt = pkt_q;
  assign asm_vld = (state_q == spl_pkg::ASM_HOLD);

  // ------------------------------
  // drop counter
  // ------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      drop_cnt <= '0;
    end
    else if (drop_now && (drop_cnt != '1))
    begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

/* rtl/spl_symbol_decoder.sv */
// receive side of a self-timed 2-of-7 link
// the link must be at all zeros when reset is released
// one symbol in flight: changes are ignored until the ack toggles
// a change of one wire only is treated as skew and waited out
// changes of three or more wires are not expected from a legal sender

`timescale 1ns/1ps

module spl_symbol_decoder
(
  input  logic             tb_clk,
  input  logic             tb_rst,
  input  spl_pkg::symbol_t sl_data,
  output logic             sl_ack,
  flit_if.sender           flit
);

  // ------------------------------
  // signals
  // ------------------------------
  // two-stage synchroniser
  spl_pkg::symbol_t sync_q1;
  spl_pkg::symbol_t sync_q2;

  // last consumed symbol
  spl_pkg::symbol_t ref_sym;
  // symbol behind the flit on offer
  spl_pkg::symbol_t cap_sym;

  spl_pkg::symbol_t    sym_diff;
  logic                sym_new;
  spl_pkg::flit_kind_e dec_kind;
  spl_pkg::nibble_t    dec_data;
  logic                flit_done;

  // ------------------------------
  // transition detect
  // ------------------------------
  // wires that toggled since last symbol
  assign sym_diff = sync_q2 ^ ref_sym;

  // a complete symbol is exactly two toggles
  assign sym_new = ($countones(sym_diff) == 2);

  assign flit_done = flit.flit_vld && flit.flit_rdy;

  // ------------------------------
  // code lookup
  // ------------------------------
  always_comb
  begin
    // anything not in the table is a bad flit
    dec_kind = spl_pkg::FLIT_BAD;
    dec_data = '0;

    if (sym_diff == spl_pkg::SYM_EOP)
    begin
      dec_kind = spl_pkg::FLIT_EOP;
    end

    for (int i = 0; i < spl_pkg::NUM_CODES; i++)
    begin
      if (sym_diff == spl_pkg::SYM_CODE[i])
      begin
        dec_kind = spl_pkg::FLIT_DATA;
        dec_data = spl_pkg::nibble_t'(i);
      end
    end
  end

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge tb_clk or posedge tb_rst)
  begin
    if (tb_rst)
    begin
      sync_q1       <= '0;
      sync_q2       <= '0;
      ref_sym       <= '0;
      flit.flit_vld <= 1'b0;
      sl_ack        <= 1'b0;
    end
    else
    begin
      sync_q1 <= sl_data;
      sync_q2 <= sync_q1;

      if (flit.flit_vld)
      begin
        // symbol consumed: move reference, answer the sender
        if (flit_done)
        begin
          flit.flit_vld <= 1'b0;
          ref_sym       <= cap_sym;
          sl_ack        <= ~sl_ack;
        end
      end
      else if (sym_new)
      begin
        flit.flit_vld <= 1'b1;
      end
    end
  end

  // flit contents, captured with the valid
  always_ff @(posedge tb_clk)
  begin
    if (!flit.flit_vld && sym_new)
    begin
      flit.flit_data <= dec_data;
      flit.flit_kind <= dec_kind;
      cap_sym        <= sync_q2;
    end
  end

endmodule

/* rtl/flit_if.sv */
// decoded flit channel between symbol decoder and packet assembler
// valid/ready; data and kind hold while valid is high

`timescale 1ns/1ps

interface flit_if;

  // flit contents, meaningful only for data flits
  spl_pkg::nibble_t    flit_data;
  spl_pkg::flit_kind_e flit_kind;

  // handshake
  logic flit_vld;
  logic flit_rdy;

  // decoder side
  modport sender (output flit_data, output flit_kind, output flit_vld, input flit_rdy);

  // assembler side
  modport receiver (input flit_data, input flit_kind, input flit_vld, output flit_rdy);

endinterface

/* rtl/spl_pkg.sv */
// shared types and constants for the link receiver
// symbol codes are transition patterns, applied by XOR to the last symbol
// packet layout is header [7:0], key [39:8], payload [71:40]
// parity in the header is carried through and never checked

package spl_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  typedef logic [6:0]  symbol_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [71:0] pkt_t;
  typedef logic [15:0] drop_cnt_t;
  // flit counter, large enough for a long packet plus one
  typedef logic [4:0]  flit_cnt_t;

  // ------------------------------
  // 2-of-7 transition codes
  // ------------------------------
  localparam int NUM_CODES = 16;

  // index is the nibble value
  localparam symbol_t SYM_CODE [NUM_CODES] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001
  };

  // end-of-packet mark
  localparam symbol_t SYM_EOP = 7'b1100000;

  // ------------------------------
  // packet fields
  // ------------------------------
  localparam int HDR_LSB     = 0;
  localparam int HDR_PLD_BIT = 1;
  localparam int PLD_LSB     = 40;
  localparam int PLD_W       = 32;

  // flit counts including header and key
  localparam flit_cnt_t FLITS_SHORT = 5'd10;
  localparam flit_cnt_t FLITS_LONG  = 5'd18;

  // ------------------------------
  // state and flit kinds
  // ------------------------------
  typedef enum logic [1:0] {FLIT_DATA, FLIT_EOP, FLIT_BAD} flit_kind_e;

  typedef enum logic [1:0] {ASM_COLLECT, ASM_HOLD, ASM_DISCARD} asm_state_e;

endpackage
